//--- design/cache_pkg.sv
package cache_pkg;

    localparam int unsigned NUM_LINES = 8;

    typedef logic [31:0]  word_t;
    typedef logic [29:0]  word_addr_t;
    typedef logic [27:0]  line_addr_t;   // {tag, index}
    typedef logic [24:0]  tag_t;
    typedef logic [2:0]   index_t;
    typedef logic [1:0]   offset_t;
    typedef logic [127:0] line_t;        // word 0 in low bits

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    typedef struct packed {
        logic       read;
        logic       write;
        line_addr_t addr;
        line_t      wdata;
    } mem_req_t;

    typedef enum logic [1:0] {
        IDLE,
        WRITE_BACK,
        REFILL
    } ctrl_state_e;

    // word address fields
    function automatic tag_t addr_tag(word_addr_t addr);
        return addr[29:5];
    endfunction

    function automatic index_t addr_index(word_addr_t addr);
        return addr[4:2];
    endfunction

    function automatic offset_t addr_offset(word_addr_t addr);
        return addr[1:0];
    endfunction

    function automatic line_addr_t addr_line(word_addr_t addr);
        return addr[29:2];
    endfunction

endpackage

//--- design/cache_tag_store.sv
module cache_tag_store (
    input  logic                  clk,
    input  logic                  proc_reset,
    input  cache_pkg::word_addr_t proc_addr,
    input  logic                  mark_dirty,
    input  logic                  fill_entry,
    output logic                  hit,
    output logic                  victim_dirty,
    output cache_pkg::tag_t       victim_tag
);

    cache_pkg::tag_entry_t entries [cache_pkg::NUM_LINES];

    cache_pkg::index_t     index;
    cache_pkg::tag_t       req_tag;
    cache_pkg::tag_entry_t cur_entry;

    assign index   = cache_pkg::addr_index(proc_addr);
    assign req_tag = cache_pkg::addr_tag(proc_addr);

    assign cur_entry = entries[index];

    // lookup on the indexed entry
    assign hit          = cur_entry.valid && (cur_entry.tag == req_tag);
    assign victim_dirty = cur_entry.dirty;   // only ever set on a valid line
    assign victim_tag   = cur_entry.tag;

    always_ff @(posedge clk)
    begin
        if (proc_reset)
        begin
            for (int i = 0; i < cache_pkg::NUM_LINES; i++)
            begin
                entries[i].valid <= 1'b0;
                entries[i].dirty <= 1'b0;
                entries[i].tag   <= '0;
            end
        end
        else if (fill_entry)
        begin
            entries[index].valid <= 1'b1;
            entries[index].dirty <= 1'b0;   // fresh from memory
            entries[index].tag   <= req_tag;
        end
        else if (mark_dirty)
        begin
            entries[index].dirty <= 1'b1;
        end
    end

endmodule

//--- design/cache_data_store.sv
module cache_data_store (
    input  logic                  clk,
    input  cache_pkg::word_addr_t proc_addr,
    input  cache_pkg::word_t      proc_wdata,
    input  logic                  write_word,
    input  logic                  fill_line,
    input  cache_pkg::line_t      mem_rdata,
    output cache_pkg::word_t      rdata,
    output cache_pkg::line_t      cur_line
);

    localparam int unsigned WORD_BITS = $bits(cache_pkg::word_t);

    cache_pkg::line_t   lines [cache_pkg::NUM_LINES];

    cache_pkg::index_t  index;
    cache_pkg::offset_t offset;

    assign index  = cache_pkg::addr_index(proc_addr);
    assign offset = cache_pkg::addr_offset(proc_addr);

    // whole indexed line for the write-back
    assign cur_line = lines[index];

    // word select within the line
    assign rdata = cur_line[offset * WORD_BITS +: WORD_BITS];

    always_ff @(posedge clk)
    begin
        if (fill_line)
        begin
            lines[index] <= mem_rdata;
        end
        else if (write_word)
        begin
            lines[index][offset * WORD_BITS +: WORD_BITS] <= proc_wdata;
        end
    end

endmodule

//--- design/cache_controller.sv
module cache_controller (
    input  logic                  clk,
    input  logic                  proc_reset,
    input  logic                  proc_read,
    input  logic                  proc_write,
    input  cache_pkg::word_addr_t proc_addr,
    input  logic                  hit,
    input  logic                  victim_dirty,
    input  cache_pkg::tag_t       victim_tag,
    input  cache_pkg::line_t      cur_line,
    input  logic                  mem_ready,
    output logic                  proc_stall,
    output logic                  mark_dirty,
    output logic                  write_word,
    output logic                  fill_entry,
    output logic                  fill_line,
    output cache_pkg::mem_req_t   mem_req
);

    cache_pkg::ctrl_state_e state_q;
    cache_pkg::ctrl_state_e state_d;

    cache_pkg::mem_req_t    req_q;
    cache_pkg::mem_req_t    req_d;

    logic                   access;
    logic                   in_idle;
    logic                   write_hit;
    logic                   refill_done;

    cache_pkg::index_t      index;
    cache_pkg::line_addr_t  req_line;
    cache_pkg::line_addr_t  victim_line;

    assign access  = proc_read || proc_write;
    assign in_idle = (state_q == cache_pkg::IDLE);

    assign index       = cache_pkg::addr_index(proc_addr);
    assign req_line    = cache_pkg::addr_line(proc_addr);
    assign victim_line = {victim_tag, index};

    // stall while busy or on a miss
    assign proc_stall = !in_idle || (access && !hit);

    assign write_hit  = in_idle && proc_write && hit;
    assign write_word = write_hit;
    assign mark_dirty = write_hit;   // dirty until evicted

    assign refill_done = (state_q == cache_pkg::REFILL) && mem_ready;
    assign fill_entry  = refill_done;
    assign fill_line   = refill_done;

    assign mem_req = req_q;

    always_comb
    begin
        state_d = state_q;
        req_d   = req_q;
        case (state_q)
            cache_pkg::IDLE:
            begin
                if (access && !hit)
                begin
                    if (victim_dirty)
                    begin
                        state_d     = cache_pkg::WRITE_BACK;
                        req_d.write = 1'b1;
                        req_d.addr  = victim_line;
                        req_d.wdata = cur_line;   // victim line out first
                    end
                    else
                    begin
                        state_d    = cache_pkg::REFILL;
                        req_d.read = 1'b1;
                        req_d.addr = req_line;
                    end
                end
            end
            cache_pkg::WRITE_BACK:
            begin
                if (mem_ready)
                begin
                    // victim is in memory, go fetch the new line
                    state_d     = cache_pkg::REFILL;
                    req_d.write = 1'b0;
                    req_d.read  = 1'b1;
                    req_d.addr  = req_line;
                end
            end
            cache_pkg::REFILL:
            begin
                if (mem_ready)
                begin
                    state_d    = cache_pkg::IDLE;   // request hits next cycle
                    req_d.read = 1'b0;
                end
            end
            default:
            begin
                state_d     = cache_pkg::IDLE;
                req_d.read  = 1'b0;
                req_d.write = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (proc_reset)
        begin
            state_q     <= cache_pkg::IDLE;
            req_q.read  <= 1'b0;
            req_q.write <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            req_q   <= req_d;
        end
    end

endmodule

//--- design/cache.sv
module cache (
    input  logic                  clk,
    input  logic                  proc_reset,
    input  logic                  proc_read,
    input  logic                  proc_write,
    input  cache_pkg::word_addr_t proc_addr,
    input  cache_pkg::word_t      proc_wdata,
    output cache_pkg::word_t      proc_rdata,
    output logic                  proc_stall,
    output cache_pkg::mem_req_t   mem_req,
    input  cache_pkg::line_t      mem_rdata,
    input  logic                  mem_ready
);

    logic             hit;
    logic             victim_dirty;
    cache_pkg::tag_t  victim_tag;
    cache_pkg::line_t cur_line;

    logic             mark_dirty;
    logic             fill_entry;
    logic             write_word;
    logic             fill_line;

    cache_tag_store tag_store0 (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .proc_addr    (proc_addr),
        .mark_dirty   (mark_dirty),
        .fill_entry   (fill_entry),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    cache_data_store data_store0 (
        .clk        (clk),
        .proc_addr  (proc_addr),
        .proc_wdata (proc_wdata),
        .write_word (write_word),
        .fill_line  (fill_line),
        .mem_rdata  (mem_rdata),
        .rdata      (proc_rdata),
        .cur_line   (cur_line)
    );

    cache_controller controller0 (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .proc_read    (proc_read),
        .proc_write   (proc_write),
        .proc_addr    (proc_addr),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .cur_line     (cur_line),
        .mem_ready    (mem_ready),
        .proc_stall   (proc_stall),
        .mark_dirty   (mark_dirty),
        .write_word   (write_word),
        .fill_entry   (fill_entry),
        .fill_line    (fill_line),
        .mem_req      (mem_req)
    );

endmodule

//--- test/tb_cache_model.svh
`ifndef TB_CACHE_MODEL_SVH
`define TB_CACHE_MODEL_SVH

localparam int KIND_HIT        = 0;
localparam int KIND_CLEAN_MISS = 1;
localparam int KIND_DIRTY_MISS = 2;

cache_pkg::word_t shadow_mem [cache_pkg::word_addr_t];   // latest value of each written word
logic             shadow_valid [cache_pkg::NUM_LINES];
logic             shadow_dirty [cache_pkg::NUM_LINES];
cache_pkg::tag_t  shadow_tag [cache_pkg::NUM_LINES];

// power-up memory contents built from every address bit
function automatic cache_pkg::word_t init_word(cache_pkg::word_addr_t addr);
    return {addr[13:0], addr[29:12]} ^ 32'h5a3c_96e1;
endfunction

function automatic cache_pkg::line_t init_line(cache_pkg::line_addr_t laddr);
    cache_pkg::line_t line;
    for (int w = 0; w < 4; w++)
    begin
        line[w * 32 +: 32] = init_word({laddr, 2'(w)});
    end
    return line;
endfunction

function automatic cache_pkg::word_t expected_word(cache_pkg::word_addr_t addr);
    if (shadow_mem.exists(addr))
    begin
        return shadow_mem[addr];
    end
    return init_word(addr);
endfunction

function automatic cache_pkg::line_t expected_line(cache_pkg::line_addr_t laddr);
    cache_pkg::line_t line;
    for (int w = 0; w < 4; w++)
    begin
        line[w * 32 +: 32] = expected_word({laddr, 2'(w)});
    end
    return line;
endfunction

function automatic int predict_access(cache_pkg::word_addr_t addr);
    cache_pkg::index_t idx;
    idx = addr[4:2];
    if (shadow_valid[idx] && (shadow_tag[idx] == addr[29:5]))
    begin
        return KIND_HIT;
    end
    if (shadow_valid[idx] && shadow_dirty[idx])
    begin
        return KIND_DIRTY_MISS;   // victim goes back to memory first
    end
    return KIND_CLEAN_MISS;
endfunction

task automatic reset_model();
    for (int i = 0; i < cache_pkg::NUM_LINES; i++)
    begin
        shadow_valid[i] = 1'b0;
        shadow_dirty[i] = 1'b0;
        shadow_tag[i]   = '0;
    end
endtask

task automatic model_fill(cache_pkg::word_addr_t addr);
    shadow_valid[addr[4:2]] = 1'b1;
    shadow_dirty[addr[4:2]] = 1'b0;
    shadow_tag[addr[4:2]]   = addr[29:5];
endtask

task automatic model_write(cache_pkg::word_addr_t addr, cache_pkg::word_t data);
    shadow_mem[addr]        = data;
    shadow_dirty[addr[4:2]] = 1'b1;   // stays dirty until evicted
endtask

`endif

//--- test/tb_cache.sv
module tb_cache;

    localparam int NUM_REQS       = 400;
    localparam int CYCLES_PER_REQ = 14;
    localparam int TIMEOUT_CYCLES = NUM_REQS * CYCLES_PER_REQ;

    typedef logic [127:0] cmp_t;

    logic                  clk = 1'b0;
    logic                  proc_reset;
    logic                  proc_read;
    logic                  proc_write;
    cache_pkg::word_addr_t proc_addr;
    cache_pkg::word_t      proc_wdata;
    cache_pkg::word_t      proc_rdata;
    logic                  proc_stall;
    cache_pkg::mem_req_t   mem_req;
    cache_pkg::line_t      mem_rdata;
    logic                  mem_ready;

    integer seed;
    int     cycle_count;
    int     error_count;

    // four tags over all indexes to force conflicts
    cache_pkg::tag_t  tag_choice [4] = '{25'h0000000, 25'h0000001, 25'h1abcdef, 25'h0f0f0f0};
    cache_pkg::line_t backing [cache_pkg::line_addr_t];   // memory contents after write-backs

    `include "tb_cache_model.svh"

    cache dut0 (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .proc_addr  (proc_addr),
        .proc_wdata (proc_wdata),
        .proc_rdata (proc_rdata),
        .proc_stall (proc_stall),
        .mem_req    (mem_req),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready)
    );

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        if (!proc_reset)
        begin
            cycle_count = cycle_count + 1;
        end
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("TESTS FAILED");
            $fatal(1, "timeout, the cache made no progress within %0d cycles", cycle_count);
        end
    end

    task automatic check_value(input string name, input cmp_t got, input cmp_t exp);
        if (got !== exp)
        begin
            error_count = error_count + 1;
            $display("Mismatch at time %0t: %s got %0h expected %0h", $time, name, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic advance_cycle();
        @(negedge clk);
        #1;   // combinational outputs settled
    endtask

    // memory with a random 1 to 4 cycle response
    initial
    begin
        integer r;
        int     delay;
        mem_ready = 1'b0;
        mem_rdata = '0;
        forever
        begin
            @(negedge clk);
            mem_ready = 1'b0;
            if (!proc_reset && (mem_req.read || mem_req.write))
            begin
                r     = $random(seed);
                delay = 1 + int'(r[1:0]);
                repeat (delay) @(negedge clk);
                if (mem_req.write)
                begin
                    backing[mem_req.addr] = mem_req.wdata;
                end
                else if (backing.exists(mem_req.addr))
                begin
                    mem_rdata = backing[mem_req.addr];
                end
                else
                begin
                    mem_rdata = init_line(mem_req.addr);
                end
                mem_ready = 1'b1;
            end
        end
    end

    initial
    begin
        integer                r;
        int                    kind;
        logic                  is_write;
        cache_pkg::word_addr_t addr;
        cache_pkg::index_t     idx;
        cache_pkg::line_addr_t victim;

        seed        = 90972;
        error_count = 0;
        proc_reset  = 1'b1;
        proc_read   = 1'b0;
        proc_write  = 1'b0;
        proc_addr   = '0;
        proc_wdata  = '0;
        reset_model();
        repeat (3) @(posedge clk);
        @(negedge clk);
        proc_reset = 1'b0;
        advance_cycle();
        check_value("proc_stall", cmp_t'(proc_stall), cmp_t'(0));
        check_value("mem_req.read", cmp_t'(mem_req.read), cmp_t'(0));
        check_value("mem_req.write", cmp_t'(mem_req.write), cmp_t'(0));

        for (int n = 0; n < NUM_REQS; n++)
        begin
            @(negedge clk);
            r = $random(seed);
            if (r[8])
            begin
                proc_read  = 1'b0;   // idle gap
                proc_write = 1'b0;
                #1;
                check_value("proc_stall", cmp_t'(proc_stall), cmp_t'(0));
                @(negedge clk);
            end
            is_write   = r[0];
            addr       = {tag_choice[r[2:1]], r[7:3]};
            idx        = addr[4:2];
            proc_read  = !is_write;
            proc_write = is_write;
            proc_addr  = addr;
            proc_wdata = $random(seed);
            kind       = predict_access(addr);
            #1;
            if (kind == KIND_HIT)
            begin
                check_value("proc_stall", cmp_t'(proc_stall), cmp_t'(0));
                check_value("mem_req.read", cmp_t'(mem_req.read), cmp_t'(0));
                check_value("mem_req.write", cmp_t'(mem_req.write), cmp_t'(0));
            end
            else
            begin
                check_value("proc_stall", cmp_t'(proc_stall), cmp_t'(1));
                while (!(mem_req.read || mem_req.write))
                begin
                    advance_cycle();
                end
                if (kind == KIND_DIRTY_MISS)
                begin
                    victim = {shadow_tag[idx], idx};
                    check_value("mem_req.write", cmp_t'(mem_req.write), cmp_t'(1));
                    check_value("mem_req.read", cmp_t'(mem_req.read), cmp_t'(0));
                    check_value("mem_req.addr", cmp_t'(mem_req.addr), cmp_t'(victim));
                    check_value("mem_req.wdata", mem_req.wdata, expected_line(victim));
                    while (!mem_req.read)
                    begin
                        advance_cycle();
                    end
                end
                check_value("mem_req.read", cmp_t'(mem_req.read), cmp_t'(1));
                check_value("mem_req.write", cmp_t'(mem_req.write), cmp_t'(0));
                check_value("mem_req.addr", cmp_t'(mem_req.addr), cmp_t'(addr[29:2]));
                while (proc_stall)
                begin
                    advance_cycle();
                end
                model_fill(addr);
            end
            if (is_write)
            begin
                model_write(addr, proc_wdata);
            end
            else
            begin
                check_value("proc_rdata", cmp_t'(proc_rdata), cmp_t'(expected_word(addr)));
            end
        end

        @(negedge clk);
        proc_read  = 1'b0;
        proc_write = 1'b0;
        #1;
        check_value("proc_stall", cmp_t'(proc_stall), cmp_t'(0));
        check_value("mem_req.read", cmp_t'(mem_req.read), cmp_t'(0));
        check_value("mem_req.write", cmp_t'(mem_req.write), cmp_t'(0));
        if (error_count == 0)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+test
design/cache_pkg.sv
design/cache_tag_store.sv
design/cache_data_store.sv
design/cache_controller.sv
design/cache.sv
test/tb_cache.sv

//--- Makefile
# Verilator build and run of the cache testbench
OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: help test clean

help:
	@echo "make help   list the targets"
	@echo "make test   build with Verilator, run the testbench, check the log"
	@echo "make clean  remove the build directory and the log"

test:
	verilator --binary --timing --top-module tb_cache -f vlog.f -Mdir $(OBJ_DIR) -o tb_cache
	-./$(OBJ_DIR)/tb_cache > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TESTS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
